// File: build.f
source/ttc_pkg.sv
source/ttc_apb_regs.sv
source/ttc_channel.sv
source/ttc_top.sv
tests/ttc_tb.sv

// File: Bender.yml
package:
  name: ttc
  description: "Triple timer/counter with an APB register interface"

sources:
  # RTL in compile order
  - source/ttc_pkg.sv
  - source/ttc_apb_regs.sv
  - source/ttc_channel.sv
  - source/ttc_top.sv

  # Testbench
  - target: test
    files:
      - tests/ttc_tb.sv

// File: tests/ttc_tb.sv
/*
 * Self-checking testbench for the triple timer/counter block.
 * Drives APB transfers into ttc_top, mirrors every channel in a cycle
 * model and compares readback and interrupt pins against it.
 */
`timescale 1ns/1ps
`default_nettype none

module ttc_tb;

   import ttc_pkg::*;

   localparam int unsigned NUM_CH      = 3;
   localparam int unsigned SEED        = 32'h0c88_8448;
   localparam int unsigned CYCLE_LIMIT = 200_000;   // 65536 overflow wait plus random phases, x2

   logic              pclk;
   logic              reset;
   logic              psel;
   logic              penable;
   logic              pwrite;
   addr_t             paddr;
   data_t             pwdata;
   data_t             prdata;
   logic [NUM_CH-1:0] interrupt;

   // Reference model, indexed by channel number 1..NUM_CH
   logic [4:0] mdl_clk_ctrl  [1:NUM_CH];   // {exp, en}
   logic [2:0] mdl_cntr_ctrl [1:NUM_CH];   // {match_en, interval_mode, disable}
   count_t     mdl_interval  [1:NUM_CH];
   count_t     mdl_match     [1:NUM_CH];
   irq_t       mdl_irq_en    [1:NUM_CH];
   irq_t       mdl_status    [1:NUM_CH];
   count_t     mdl_counter   [1:NUM_CH];
   int         mdl_psc       [1:NUM_CH];   // Prescaler, 16-bit range

   int unsigned errors    = 0;
   int unsigned passes    = 0;
   int unsigned cycles    = 0;
   int unsigned test_err0 = 0;             // Error count when a test began

   ttc_top #(
      .NUM_CH (NUM_CH)
   ) i_dut (
      .pclk      (pclk),
      .reset     (reset),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .interrupt (interrupt)
   );

   initial begin
      pclk = 1'b0;
      forever #5 pclk = ~pclk;              // 10 ns period
   end

   // Hard stop if something never finishes
   always @(posedge pclk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Run stopped: cycle limit of %0d reached before the tests finished",
                  CYCLE_LIMIT);
         $display(">>> FAIL");
         $finish;
      end
   end

   // ------------------------------------------------------------
   // Reference model
   // ------------------------------------------------------------
   function automatic addr_t make_addr(input int ch, input int idx);
      return {1'b0, 2'(ch), 3'(idx), 2'b00};     // Bits 6:5 channel, 4:2 index
   endfunction

   function automatic data_t model_read(input addr_t addr);
      int ch;
      ch = addr[6:5];
      if (ch < 1 || ch > NUM_CH) begin
         return '0;                              // Unmapped channel
      end
      case (addr[4:2])
         REG_CLK_CTRL:   return data_t'(mdl_clk_ctrl[ch]);
         REG_CNTR_CTRL:  return data_t'(mdl_cntr_ctrl[ch]);
         REG_COUNTER:    return data_t'(mdl_counter[ch]);
         REG_INTERVAL:   return data_t'(mdl_interval[ch]);
         REG_MATCH:      return data_t'(mdl_match[ch]);
         REG_IRQ_STATUS: return data_t'(mdl_status[ch]);
         REG_IRQ_EN:     return data_t'(mdl_irq_en[ch]);
         default:        return '0;
      endcase
   endfunction

   // One clock of a channel, using the values before the edge
   function automatic void step_channel(input int c, input logic restart, input logic clear);
      logic   tick;
      int     period;
      int     exp_v;
      irq_t   ev;
      count_t nxt;
      exp_v  = mdl_clk_ctrl[c][4:1];
      period = 1 << (exp_v + 1);
      ev     = '0;
      tick   = !mdl_cntr_ctrl[c][0] && !restart;
      if (mdl_clk_ctrl[c][0]) begin
         tick = tick && ((mdl_psc[c] % period) == period - 1);
      end
      if (mdl_cntr_ctrl[c][1] && mdl_counter[c] == mdl_interval[c]) begin
         nxt       = '0;
         ev[IRQ_INT] = tick;
      end else if (!mdl_cntr_ctrl[c][1] && mdl_counter[c] == 16'hffff) begin
         nxt       = '0;
         ev[IRQ_OVF] = tick;
      end else begin
         nxt = mdl_counter[c] + 16'd1;           // Interval mode past limit just rolls
      end
      if (tick && mdl_cntr_ctrl[c][2] && nxt == mdl_match[c]) begin
         ev[IRQ_MATCH] = 1'b1;
      end
      if (restart) begin
         mdl_counter[c] = '0;
         mdl_psc[c]     = 0;
      end else begin
         if (tick) begin
            mdl_counter[c] = nxt;
         end
         if (!mdl_cntr_ctrl[c][0] && mdl_clk_ctrl[c][0]) begin
            mdl_psc[c] = (mdl_psc[c] + 1) % 65536;
         end
      end
      mdl_status[c] = (clear ? irq_t'(0) : mdl_status[c]) | ev;   // Event wins over clear
   endfunction

   function automatic void apply_write(input int c, input reg_idx_t idx, input data_t d);
      case (idx)
         REG_CLK_CTRL:  mdl_clk_ctrl[c]  = d[4:0];
         REG_CNTR_CTRL: mdl_cntr_ctrl[c] = d[2:0];   // Restart never stored
         REG_INTERVAL:  mdl_interval[c]  = d[15:0];
         REG_MATCH:     mdl_match[c]     = d[15:0];
         REG_IRQ_EN:    mdl_irq_en[c]    = d[2:0];
         default: ;                                  // Read only or unmapped
      endcase
   endfunction

   always @(posedge pclk) begin : model_step
      int       ch;
      reg_idx_t idx;
      logic     hit;
      ch  = paddr[6:5];
      idx = paddr[4:2];
      for (int c = 1; c <= NUM_CH; c++) begin
         if (reset) begin
            mdl_clk_ctrl[c]  = '0;
            mdl_cntr_ctrl[c] = '0;
            mdl_interval[c]  = '0;
            mdl_match[c]     = '0;
            mdl_irq_en[c]    = '0;
            mdl_status[c]    = '0;
            mdl_counter[c]   = '0;
            mdl_psc[c]       = 0;
         end else begin
            hit = psel && penable && (ch == c);     // Access edge of this channel
            step_channel(c, hit && pwrite && idx == REG_CNTR_CTRL && pwdata[RESTART_BIT],
                         hit && !pwrite && idx == REG_IRQ_STATUS);
            if (hit && pwrite) begin
               apply_write(c, idx, pwdata);
            end
         end
      end
   end

   // Pins against status AND enable, mid-cycle
   always @(negedge pclk) begin : irq_check
      logic expected;
      if (!reset) begin
         for (int c = 1; c <= NUM_CH; c++) begin
            expected = |(mdl_status[c] & mdl_irq_en[c]);
            assert (interrupt[c-1] === expected) passes++;
            else begin
               errors++;
               $display("Mismatch at %0t: interrupt of channel %0d expected %0b got %0b",
                        $time, c, expected, interrupt[c-1]);
            end
         end
      end
   end

   // ------------------------------------------------------------
   // APB and check helpers, entered 1 ns after a rising edge
   // ------------------------------------------------------------
   task automatic apb_write(input addr_t addr, input data_t data);
      psel    = 1'b1;                            // Setup
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(posedge pclk);
      #1;
      penable = 1'b1;                            // Access
      @(posedge pclk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input addr_t addr, output data_t got, output data_t exp_val);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(posedge pclk);
      #1;
      penable = 1'b1;
      @(negedge pclk);                           // prdata settled in access cycle
      got     = prdata;
      exp_val = model_read(addr);
      @(posedge pclk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic compare_value(input addr_t addr, input data_t exp_val, input data_t got);
      assert (got === exp_val) passes++;
      else begin
         errors++;
         $display("Mismatch at %0t: addr 0x%02h expected 0x%08h got 0x%08h",
                  $time, addr, exp_val, got);
      end
   endtask

   task automatic read_and_compare(input addr_t addr);
      data_t got;
      data_t exp_val;
      apb_read(addr, got, exp_val);
      compare_value(addr, exp_val, got);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge pclk);
         #1;
      end
   endtask

   task automatic wait_irq(input int ch, input int limit, input string what);
      int n;
      n = 0;
      while (interrupt[ch-1] !== 1'b1 && n < limit) begin
         @(posedge pclk);
         #1;
         n++;
      end
      assert (interrupt[ch-1] === 1'b1) passes++;
      else begin
         errors++;
         $display("Interrupt of channel %0d did not rise within %0d cycles (%s flag)",
                  ch, limit, what);
      end
   endtask

   task automatic flag_set(input data_t status, input int bit_pos, input int ch);
      assert (status[bit_pos] === 1'b1) passes++;
      else begin
         errors++;
         $display("Status flag %0d of channel %0d not set when expected", bit_pos, ch);
      end
   endtask

   task automatic report_test(input string name);
      $display("[%0t] %s finished, %0d errors", $time, name, errors - test_err0);
      test_err0 = errors;
   endtask

   // ------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------
   task automatic reset_state();
      assert (interrupt === '0) passes++;
      else begin
         errors++;
         $display("Interrupt pins not all low after reset");
      end
      for (int c = 1; c <= NUM_CH; c++) begin
         for (int r = 0; r < 7; r++) begin
            read_and_compare(make_addr(c, r));   // Counter follows model from zero
         end
      end
      report_test("reset_state");
   endtask

   task automatic register_access();
      addr_t addr;
      data_t got;
      data_t exp_val;
      for (int n = 0; n < 150; n++) begin
         addr = make_addr($urandom_range(NUM_CH, 1), $urandom_range(7, 0));
         apb_write(addr, $urandom);
         read_and_compare(addr);                 // Masked to field width
      end
      for (int n = 0; n < 20; n++) begin
         if ($urandom_range(1, 0)) begin
            addr = make_addr(0, $urandom_range(7, 0));
         end else begin
            addr = make_addr($urandom_range(NUM_CH, 1), 7);
         end
         apb_write(addr, $urandom);              // Must be ignored
         apb_read(addr, got, exp_val);
         compare_value(addr, '0, got);
      end
      report_test("register_access");
   endtask

   task automatic prescale_mix();
      int ch;
      for (int n = 0; n < 40; n++) begin
         ch = $urandom_range(NUM_CH, 1);
         apb_write(make_addr(ch, REG_CLK_CTRL),
                   ($urandom_range(3, 0) << 1) | $urandom_range(1, 0));
         apb_write(make_addr(ch, REG_CNTR_CTRL),
                   ($urandom_range(1, 0) << RESTART_BIT) | ($urandom_range(3, 0) == 0));
         idle($urandom_range(40, 0));
         read_and_compare(make_addr(ch, REG_COUNTER));
      end
      report_test("prescale_mix");
   endtask

   task automatic wrap_flags();
      int    ch;
      int    ival;
      data_t got;
      data_t exp_val;
      for (int n = 0; n < 3; n++) begin
         ch   = $urandom_range(NUM_CH, 1);
         ival = $urandom_range(20, 2);
         apb_write(make_addr(ch, REG_CLK_CTRL), '0);
         apb_write(make_addr(ch, REG_INTERVAL), ival);
         apb_write(make_addr(ch, REG_IRQ_EN), 32'h2);
         apb_write(make_addr(ch, REG_CNTR_CTRL), 32'h12);   // Restart, interval mode
         read_and_compare(make_addr(ch, REG_IRQ_STATUS));   // Drop stale flags
         wait_irq(ch, ival + 8, "interval");
         read_and_compare(make_addr(ch, REG_COUNTER));
         apb_read(make_addr(ch, REG_IRQ_STATUS), got, exp_val);
         compare_value(make_addr(ch, REG_IRQ_STATUS), exp_val, got);
         flag_set(got, IRQ_INT, ch);
      end
      // Free running, full 16-bit wrap
      ch = $urandom_range(NUM_CH, 1);
      apb_write(make_addr(ch, REG_CLK_CTRL), '0);
      apb_write(make_addr(ch, REG_IRQ_EN), 32'h1);
      apb_write(make_addr(ch, REG_CNTR_CTRL), 32'h10);
      read_and_compare(make_addr(ch, REG_IRQ_STATUS));
      wait_irq(ch, 70_000, "overflow");
      apb_read(make_addr(ch, REG_IRQ_STATUS), got, exp_val);
      compare_value(make_addr(ch, REG_IRQ_STATUS), exp_val, got);
      flag_set(got, IRQ_OVF, ch);
      report_test("wrap_flags");
   endtask

   task automatic match_and_masks();
      int    ch;
      int    mval;
      data_t got;
      data_t exp_val;
      ch   = $urandom_range(NUM_CH, 1);
      mval = $urandom_range(40, 5);
      apb_write(make_addr(ch, REG_CLK_CTRL), '0);
      apb_write(make_addr(ch, REG_MATCH), mval);
      apb_write(make_addr(ch, REG_IRQ_EN), $urandom_range(7, 0) | 4);
      apb_write(make_addr(ch, REG_CNTR_CTRL), 32'h14);      // Restart, match_en
      read_and_compare(make_addr(ch, REG_IRQ_STATUS));
      wait_irq(ch, mval + 8, "match");
      apb_read(make_addr(ch, REG_IRQ_STATUS), got, exp_val);
      compare_value(make_addr(ch, REG_IRQ_STATUS), exp_val, got);
      flag_set(got, IRQ_MATCH, ch);
      // Busy channels under random masks, pins watched every cycle
      for (int n = 0; n < 40; n++) begin
         ch = $urandom_range(NUM_CH, 1);
         apb_write(make_addr(ch, REG_INTERVAL), $urandom_range(15, 0));
         apb_write(make_addr(ch, REG_MATCH), $urandom_range(15, 0));
         apb_write(make_addr(ch, REG_CNTR_CTRL), ($urandom_range(1, 0) << 2) | 2);
         apb_write(make_addr(ch, REG_IRQ_EN), $urandom);
         idle($urandom_range(20, 0));
         if ($urandom_range(1, 0)) begin
            read_and_compare(make_addr(ch, REG_IRQ_STATUS));
         end
      end
      report_test("match_and_masks");
   endtask

   task automatic clear_on_read();
      int    ch;
      data_t got;
      data_t exp_val;
      for (int n = 0; n < 3; n++) begin
         ch = $urandom_range(NUM_CH, 1);
         apb_write(make_addr(ch, REG_CLK_CTRL), '0);
         apb_write(make_addr(ch, REG_INTERVAL), 40);         // Next event far away
         apb_write(make_addr(ch, REG_IRQ_EN), 32'h2);
         apb_write(make_addr(ch, REG_CNTR_CTRL), 32'h12);
         read_and_compare(make_addr(ch, REG_IRQ_STATUS));
         wait_irq(ch, 60, "interval");
         apb_read(make_addr(ch, REG_IRQ_STATUS), got, exp_val);
         compare_value(make_addr(ch, REG_IRQ_STATUS), exp_val, got);
         flag_set(got, IRQ_INT, ch);
         assert (interrupt[ch-1] === 1'b0) passes++;
         else begin
            errors++;
            $display("Interrupt of channel %0d still high after the clearing read", ch);
         end
         read_and_compare(make_addr(ch, REG_IRQ_STATUS));    // Second read
         // Fast events racing the clear
         apb_write(make_addr(ch, REG_INTERVAL), $urandom_range(3, 0));
         apb_write(make_addr(ch, REG_CNTR_CTRL), 32'h12);
         repeat (10) begin
            read_and_compare(make_addr(ch, REG_IRQ_STATUS));
         end
      end
      report_test("clear_on_read");
   endtask

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial begin : main
      void'($urandom(SEED));
      reset   = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      repeat (16) @(posedge pclk);
      #1;
      reset = 1'b0;

      reset_state();
      register_access();
      prescale_mix();
      wrap_flags();
      match_and_masks();
      clear_on_read();

      $display("Checks passed: %0d, errors: %0d", passes, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: source/ttc_top.sv
/*
 * Top level of the triple timer/counter on APB.
 * Bundles the APB pins, connects the register interface to NUM_CH
 * channel instances and brings out one interrupt pin per channel.
 */
`timescale 1ns/1ps
`default_nettype none

module ttc_top #(
   parameter int unsigned NUM_CH = 3      // Channels, 1 to 3
) (
   input  logic               pclk,
   input  logic               reset,      // Sync, active high
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  ttc_pkg::addr_t     paddr,
   input  ttc_pkg::data_t     pwdata,
   output ttc_pkg::data_t     prdata,
   output logic [NUM_CH-1:0]  interrupt   // Bit i is channel i+1
);

   import ttc_pkg::*;

   apb_req_t apb;                         // APB pins as one bundle
   ch_wr_t   ch_wr   [NUM_CH];            // Strobes to channels
   ch_view_t ch_view [NUM_CH];            // Readback from channels

   assign apb = '{
      psel:    psel,
      penable: penable,
      pwrite:  pwrite,
      paddr:   paddr,
      pwdata:  pwdata
   };

   // ------------------------------------------------------------
   // Register interface and channels
   // ------------------------------------------------------------
   ttc_apb_regs #(
      .NUM_CH (NUM_CH)
   ) i_apb_regs (
      .pclk   (pclk),
      .reset  (reset),
      .apb    (apb),
      .views  (ch_view),
      .wr     (ch_wr),
      .prdata (prdata)
   );

   for (genvar i = 0; i < NUM_CH; i++) begin : g_channel
      ttc_channel i_channel (
         .pclk  (pclk),
         .reset (reset),
         .wr    (ch_wr[i]),
         .view  (ch_view[i]),
         .irq   (interrupt[i])
      );
   end

endmodule

`default_nettype wire

// File: source/ttc_channel.sv
/*
 * One timer/counter channel.
 * Holds its clock and counter control, interval, match and interrupt
 * registers, a prescaler that produces the count tick, the 16-bit
 * counter with interval or free-running wrap, and the match compare.
 */
`timescale 1ns/1ps
`default_nettype none

module ttc_channel (
   input  logic              pclk,
   input  logic              reset,
   input  ttc_pkg::ch_wr_t   wr,
   output ttc_pkg::ch_view_t view,
   output logic              irq
);

   import ttc_pkg::*;

   // Programmed registers
   clk_ctrl_t  clk_ctrl;
   cntr_ctrl_t cntr_ctrl;
   count_t     interval;
   count_t     match;
   irq_t       irq_en;
   irq_t       irq_status;

   // Counting datapath
   count_t     counter;
   count_t     psc_cnt;         // Prescaler, free running while enabled
   count_t     psc_mask;        // Low exp+1 bits set
   count_t     counter_nxt;
   logic       restart;         // Counter restart write
   logic       tick;            // Counter advances this edge
   logic       interval_hit;
   logic       overflow_hit;
   irq_t       events;          // Flags raised this edge

   assign restart = wr.cntr_ctrl_wr && wr.wdata[RESTART_BIT];

   // ------------------------------------------------------------
   // Register writes
   // ------------------------------------------------------------
   always_ff @(posedge pclk) begin
      if (reset) begin
         clk_ctrl  <= '0;
         cntr_ctrl <= '0;                 // Enabled, free running
         interval  <= '0;
         match     <= '0;
         irq_en    <= '0;
      end else begin
         if (wr.clk_ctrl_wr) begin
            clk_ctrl <= clk_ctrl_t'(wr.wdata[$bits(clk_ctrl_t)-1:0]);
         end
         if (wr.cntr_ctrl_wr) begin
            cntr_ctrl <= cntr_ctrl_t'(wr.wdata[$bits(cntr_ctrl_t)-1:0]);
         end
         if (wr.interval_wr) begin
            interval <= wr.wdata[$bits(count_t)-1:0];
         end
         if (wr.match_wr) begin
            match <= wr.wdata[$bits(count_t)-1:0];
         end
         if (wr.irq_en_wr) begin
            irq_en <= wr.wdata[$bits(irq_t)-1:0];
         end
      end
   end

   // ------------------------------------------------------------
   // Prescaler and tick
   // ------------------------------------------------------------
   // Exp 15 gives a full 16-bit mask, period 2**16
   assign psc_mask = ~(count_t'('1) << ({1'b0, clk_ctrl.prescale_exp} + 5'd1));

   always_comb begin
      tick = !cntr_ctrl.cnt_disable && !restart;
      if (clk_ctrl.prescale_en) begin
         tick = tick && ((psc_cnt & psc_mask) == psc_mask);   // Low bits all ones
      end
   end

   always_ff @(posedge pclk) begin
      if (reset || restart) begin
         psc_cnt <= '0;
      end else if (!cntr_ctrl.cnt_disable && clk_ctrl.prescale_en) begin
         psc_cnt <= psc_cnt + 1'b1;       // Wraps modulo 2**16
      end
   end

   // ------------------------------------------------------------
   // Counter and event detection
   // ------------------------------------------------------------
   assign interval_hit = cntr_ctrl.interval_mode && (counter == interval);
   // In interval mode a counter above interval just rolls over, no flag
   assign overflow_hit = !cntr_ctrl.interval_mode && (counter == count_t'('1));

   assign counter_nxt = (interval_hit || overflow_hit) ? '0 : counter + 1'b1;

   always_comb begin
      events            = '0;
      events[IRQ_OVF]   = tick && overflow_hit;
      events[IRQ_INT]   = tick && interval_hit;
      events[IRQ_MATCH] = tick && cntr_ctrl.match_en && (counter_nxt == match);
   end

   always_ff @(posedge pclk) begin
      if (reset || restart) begin
         counter <= '0;                   // Restart takes no tick
      end else if (tick) begin
         counter <= counter_nxt;
      end
   end

   // ------------------------------------------------------------
   // Interrupt status
   // ------------------------------------------------------------
   always_ff @(posedge pclk) begin
      if (reset) begin
         irq_status <= '0;
      end else begin
         // New event beats a clearing read on the same edge
         irq_status <= (wr.status_clr ? irq_t'(0) : irq_status) | events;
      end
   end

   assign irq = |(irq_status & irq_en);  // Same-cycle from registers

   assign view = '{
      clk_ctrl:   clk_ctrl,
      cntr_ctrl:  cntr_ctrl,
      counter:    counter,
      interval:   interval,
      match:      match,
      irq_status: irq_status,
      irq_en:     irq_en
   };

   // ------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------
   // Decode never hits two registers of this channel at once
   a_one_strobe: assert property (
      @(posedge pclk) disable iff (reset)
      $onehot0({wr.clk_ctrl_wr, wr.cntr_ctrl_wr, wr.interval_wr,
                wr.match_wr, wr.irq_en_wr, wr.status_clr})
   );

   // Disabled counter frozen until a restart
   a_disable_holds: assert property (
      @(posedge pclk) disable iff (reset)
      cntr_ctrl.cnt_disable && !restart |=> $stable(counter)
   );

endmodule

`default_nettype wire

// File: source/ttc_apb_regs.sv
/*
 * APB register interface of the timer/counter block.
 * Decodes channel and register index in the access cycle, raises the
 * per-channel write and status-clear strobes and muxes read data back
 * from the channel views. Purely combinational apart from its checks.
 */
`timescale 1ns/1ps
`default_nettype none

module ttc_apb_regs #(
   parameter int unsigned NUM_CH = 3      // Channels present, 1 to 3
) (
   input  logic              pclk,
   input  logic              reset,
   input  ttc_pkg::apb_req_t apb,
   input  ttc_pkg::ch_view_t views [NUM_CH],
   output ttc_pkg::ch_wr_t   wr    [NUM_CH],
   output ttc_pkg::data_t    prdata
);

   import ttc_pkg::*;

   localparam int unsigned STRB_W = 6;    // Strobes per channel

   logic                       access;     // Second APB phase
   logic                       wr_access;
   logic                       rd_access;
   logic [1:0]                 ch_sel;     // 1..3, 0 unmapped
   reg_idx_t                   reg_idx;
   logic [NUM_CH*STRB_W-1:0]   all_strb;   // Every strobe, for the checks

   // Two-bit channel field cannot address more than three channels
   if (NUM_CH < 1 || NUM_CH > 3) begin : g_bad_num_ch
      $error("NUM_CH must be 1 to 3");
   end

   // ------------------------------------------------------------
   // Address decode
   // ------------------------------------------------------------
   assign access    = apb.psel && apb.penable;
   assign wr_access = access && apb.pwrite;
   assign rd_access = access && !apb.pwrite;
   assign ch_sel    = apb.paddr[6:5];
   assign reg_idx   = apb.paddr[4:2];       // Word index, byte bits ignored

   // Zero-extended field of one channel for readback
   function automatic data_t read_field(input ch_view_t v, input reg_idx_t idx);
      data_t d;
      d = '0;
      case (idx)
         REG_CLK_CTRL:   d = data_t'(v.clk_ctrl);
         REG_CNTR_CTRL:  d = data_t'(v.cntr_ctrl);   // Restart reads as 0
         REG_COUNTER:    d = data_t'(v.counter);
         REG_INTERVAL:   d = data_t'(v.interval);
         REG_MATCH:      d = data_t'(v.match);
         REG_IRQ_STATUS: d = data_t'(v.irq_status);
         REG_IRQ_EN:     d = data_t'(v.irq_en);
         default:        d = '0;                      // Index 7 unmapped
      endcase
      return d;
   endfunction

   // ------------------------------------------------------------
   // Per-channel strobes
   // ------------------------------------------------------------
   for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
      logic hit;                                      // This channel addressed

      assign hit = (ch_sel == 2'(i + 1));

      assign wr[i].clk_ctrl_wr  = wr_access && hit && (reg_idx == REG_CLK_CTRL);
      assign wr[i].cntr_ctrl_wr = wr_access && hit && (reg_idx == REG_CNTR_CTRL);
      assign wr[i].interval_wr  = wr_access && hit && (reg_idx == REG_INTERVAL);
      assign wr[i].match_wr     = wr_access && hit && (reg_idx == REG_MATCH);
      assign wr[i].irq_en_wr    = wr_access && hit && (reg_idx == REG_IRQ_EN);
      // Read side effect on the status register
      assign wr[i].status_clr   = rd_access && hit && (reg_idx == REG_IRQ_STATUS);
      assign wr[i].wdata        = apb.pwdata;         // Shared write bus

      assign all_strb[i*STRB_W +: STRB_W] = {
         wr[i].clk_ctrl_wr,
         wr[i].cntr_ctrl_wr,
         wr[i].interval_wr,
         wr[i].match_wr,
         wr[i].irq_en_wr,
         wr[i].status_clr
      };
   end

   // ------------------------------------------------------------
   // Read data mux
   // ------------------------------------------------------------
   always_comb begin
      prdata = '0;                                    // Idle and unmapped read 0
      for (int i = 0; i < NUM_CH; i++) begin
         if (rd_access && (ch_sel == 2'(i + 1))) begin
            prdata = read_field(views[i], reg_idx);
         end
      end
   end

   // ------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------
   // Access phase only ever follows a selected setup
   a_penable_psel: assert property (
      @(posedge pclk) disable iff (reset)
      apb.penable |-> apb.psel
   );

   // One register touched per transfer across the whole block
   a_strobe_onehot: assert property (
      @(posedge pclk) disable iff (reset)
      $onehot0(all_strb)
   );

endmodule

`default_nettype wire

// File: source/ttc_pkg.sv
/*
 * Shared types for the triple timer/counter block.
 * Holds the APB widths, channel register indices, interrupt bit
 * positions and the packed structs passed between register decode
 * and the channels. Import it wherever these types are used.
 */
`default_nettype none

package ttc_pkg;

   typedef logic [7:0]  addr_t;        // APB byte address
   typedef logic [31:0] data_t;        // APB data word
   typedef logic [15:0] count_t;       // Counter, interval, match
   typedef logic [2:0]  irq_t;         // Interrupt flag set
   typedef logic [2:0]  reg_idx_t;     // Register index in a channel

   // Register map within one channel ----------------------------
   localparam reg_idx_t REG_CLK_CTRL   = 3'd0;
   localparam reg_idx_t REG_CNTR_CTRL  = 3'd1;
   localparam reg_idx_t REG_COUNTER    = 3'd2;  // Read only
   localparam reg_idx_t REG_INTERVAL   = 3'd3;
   localparam reg_idx_t REG_MATCH      = 3'd4;
   localparam reg_idx_t REG_IRQ_STATUS = 3'd5;  // Read only, clear on read
   localparam reg_idx_t REG_IRQ_EN     = 3'd6;

   localparam int unsigned IRQ_OVF     = 0;     // Overflow flag
   localparam int unsigned IRQ_INT     = 1;     // Interval flag
   localparam int unsigned IRQ_MATCH   = 2;     // Match flag
   localparam int unsigned RESTART_BIT = 4;     // Self-clearing restart in cntr_ctrl write

   typedef struct packed {
      logic [3:0] prescale_exp;   // Tick every 2**(exp+1) clocks
      logic       prescale_en;    // Bit 0
   } clk_ctrl_t;

   typedef struct packed {
      logic match_en;             // Bit 2
      logic interval_mode;        // Bit 1
      logic cnt_disable;          // Bit 0, counter held when set
   } cntr_ctrl_t;

   typedef struct packed {
      logic  psel;
      logic  penable;
      logic  pwrite;
      addr_t paddr;
      data_t pwdata;
   } apb_req_t;

   // Strobes into one channel, all single cycle
   typedef struct packed {
      logic  clk_ctrl_wr;
      logic  cntr_ctrl_wr;
      logic  interval_wr;
      logic  match_wr;
      logic  irq_en_wr;
      logic  status_clr;
      data_t wdata;
   } ch_wr_t;

   // Readback of one channel
   typedef struct packed {
      clk_ctrl_t  clk_ctrl;
      cntr_ctrl_t cntr_ctrl;
      count_t     counter;
      count_t     interval;
      count_t     match;
      irq_t       irq_status;
      irq_t       irq_en;
   } ch_view_t;

endpackage

`default_nettype wire
